//--- list.f
+incdir+tests
src/decomp_pkg.sv
src/byte_unpacker.sv
src/token_fsm.sv
src/history_buffer.sv
src/line_packer.sv
src/burst_counter.sv
src/snappy_decomp_top.sv
tests/tb_snappy_decomp.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# exit status is nonzero when the simulation stops on $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --timescale 1ns/1ns \
	--top-module tb_snappy_decomp -f list.f -o tb_snappy_decomp
./obj_dir/tb_snappy_decomp

//--- src/burst_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// marks every 16th line and the final line of a job
// last_o only means something while a line is valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module burst_counter
	import decomp_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start_i,
	input  logic handshake_i,
	input  logic final_i,
	output logic last_o,
	output logic done_o
);

	localparam int CNT_W = $clog2(BURST_LINES);

	logic [CNT_W-1:0] line_cnt_q;   // lines accepted in this burst
	logic             done_q;

	assign last_o = (line_cnt_q == CNT_W'(BURST_LINES-1)) | final_i;
	assign done_o = done_q;

	always_ff @(posedge clk) begin
		if (!rst_n || start_i)
			line_cnt_q <= '0;
		else if (handshake_i)
			line_cnt_q <= line_cnt_q + 1'b1;   // rolls over at burst end
	end

	// one cycle after the final line leaves
	always_ff @(posedge clk) begin
		if (!rst_n)
			done_q <= 1'b0;
		else
			done_q <= handshake_i & final_i;
	end

endmodule

//--- src/byte_unpacker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// beat fifo feeding one compressed byte per take
// byte 0 of a beat sits in bits 7:0
// bytes past the compressed length are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module byte_unpacker
	import decomp_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start_i,
	input  logic [CLEN_W-1:0]       clen_i,
	input  logic [BEAT_BYTES*8-1:0] data_i,
	input  logic                    valid_i,
	input  logic                    take_i,
	output logic                    almostfull_o,
	output logic [7:0]              byte_o,
	output logic                    byte_valid_o,
	output logic                    stream_end_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int IDX_W = $clog2(BEAT_BYTES);

	logic [BEAT_BYTES*8-1:0] fifo_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]        wr_ptr_q;
	logic [PTR_W-1:0]        rd_ptr_q;
	logic [PTR_W:0]          count_q;
	logic [IDX_W-1:0]        byte_idx_q;
	logic [CLEN_W-1:0]       remaining_q;
	logic                    push;
	logic                    pop;
	logic                    take_ok;

	assign almostfull_o = (count_q >= (PTR_W+1)'(FIFO_AFULL));
	assign push         = valid_i & ~almostfull_o;   // beats are ignored while almost full
	assign stream_end_o = (remaining_q == '0);
	assign byte_valid_o = (count_q != '0) & ~stream_end_o;
	assign byte_o       = fifo_mem[rd_ptr_q][byte_idx_q*8 +: 8];
	assign take_ok      = take_i & byte_valid_o;

	// head beat leaves after its last byte, or early at end of stream
	assign pop = take_ok & ((byte_idx_q == IDX_W'(BEAT_BYTES-1)) | (remaining_q == 1));

	always_ff @(posedge clk) begin
		if (push)
			fifo_mem[wr_ptr_q] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			count_q     <= '0;
			byte_idx_q  <= '0;
			remaining_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);

			if (start_i) begin
				remaining_q <= clen_i;
				byte_idx_q  <= '0;
			end else if (take_ok) begin
				remaining_q <= remaining_q - 1'b1;
				byte_idx_q  <= pop ? '0 : byte_idx_q + 1'b1;
			end
		end
	end

endmodule

//--- src/decomp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, depths and enums of the decompressor
// only literal and one-byte-offset copy tokens are decoded
// copy offsets are limited by the history size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package decomp_pkg;

	// input and output bus geometry
	localparam int BEAT_BYTES  = 64;
	localparam int LINE_BYTES  = 64;

	// input beat fifo
	localparam int FIFO_DEPTH  = 4;
	localparam int FIFO_AFULL  = 2;   // fill level that raises almost-full

	// history window for copies
	localparam int HIST_BYTES  = 2048;
	localparam int HIST_AW     = 11;

	localparam int BURST_LINES = 16;  // output lines per burst

	// job length widths
	localparam int CLEN_W      = 35;
	localparam int DLEN_W      = 32;

	// token type, taken from tag bits 1:0
	typedef enum logic [1:0] {
		TAG_LITERAL = 2'd0,
		TAG_COPY1   = 2'd1,
		TAG_COPY2   = 2'd2,   // not supported
		TAG_COPY4   = 2'd3    // not supported
	} tag_e;

	// token parser states
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_TAG  = 3'd1,
		ST_LIT  = 3'd2,
		ST_OFS  = 3'd3,
		ST_COPY = 3'd4
	} fsm_state_e;

endpackage

//--- src/history_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular window of the last 2048 output bytes
// offset 0 is not a legal copy distance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module history_buffer
	import decomp_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start_i,
	input  logic               wr_i,
	input  logic [7:0]         byte_i,
	input  logic [HIST_AW-1:0] offset_i,
	output logic [7:0]         rd_byte_o
);

	logic [7:0]         hist_mem [HIST_BYTES];
	logic [HIST_AW-1:0] wr_ptr_q;
	logic [HIST_AW-1:0] rd_addr;

	// wraps naturally at the window size
	assign rd_addr   = wr_ptr_q - offset_i;
	assign rd_byte_o = hist_mem[rd_addr];   // offset 1 gives the newest byte

	always_ff @(posedge clk) begin
		if (wr_i)
			hist_mem[wr_ptr_q] <= byte_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || start_i)
			wr_ptr_q <= '0;
		else if (wr_i)
			wr_ptr_q <= wr_ptr_q + 1'b1;
	end

endmodule

//--- src/line_packer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packs output bytes into 64-byte lines with a mask
// a closed line blocks new bytes until it is taken
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module line_packer
	import decomp_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start_i,
	input  logic [DLEN_W-1:0]       dlen_i,
	input  logic [7:0]              byte_i,
	input  logic                    byte_valid_i,
	input  logic                    ready_i,
	output logic [LINE_BYTES*8-1:0] data_o,
	output logic [LINE_BYTES-1:0]   byte_en_o,
	output logic                    valid_o,
	output logic                    final_o,
	output logic                    full_o
);

	localparam int LANE_W = $clog2(LINE_BYTES);

	logic [LINE_BYTES*8-1:0] data_q;
	logic [LINE_BYTES-1:0]   mask_q;
	logic [LANE_W-1:0]       lane_q;
	logic [DLEN_W-1:0]       rem_q;     // bytes still to come
	logic                    valid_q;
	logic                    final_q;
	logic                    append;
	logic                    handshake;

	assign append    = byte_valid_i & ~valid_q;
	assign handshake = valid_q & ready_i;

	assign data_o    = data_q;
	assign byte_en_o = mask_q;
	assign valid_o   = valid_q;
	assign final_o   = final_q;
	assign full_o    = valid_q;

	always_ff @(posedge clk) begin
		if (handshake)
			data_q <= '0;
		else if (append)
			data_q[lane_q*8 +: 8] <= byte_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mask_q  <= '0;
			lane_q  <= '0;
			rem_q   <= '0;
			valid_q <= 1'b0;
			final_q <= 1'b0;
		end else if (start_i) begin
			mask_q  <= '0;
			lane_q  <= '0;
			rem_q   <= dlen_i;
			valid_q <= 1'b0;
			final_q <= 1'b0;
		end else if (handshake) begin
			mask_q  <= '0;
			valid_q <= 1'b0;
			final_q <= 1'b0;
		end else if (append) begin
			mask_q[lane_q] <= 1'b1;
			lane_q         <= lane_q + 1'b1;   // wraps to lane 0 after lane 63
			rem_q          <= rem_q - 1'b1;
			if (lane_q == LANE_W'(LINE_BYTES-1) || rem_q == 1) begin
				valid_q <= 1'b1;
				final_q <= (rem_q == 1);
			end
		end
	end

endmodule

//--- src/snappy_decomp_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-serial snappy-style decompressor
// both lengths are sampled on the start pulse
// a beat is taken when valid_i is high and almostfull_o low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module snappy_decomp_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 start_i,
	input  logic [decomp_pkg::CLEN_W-1:0]        clen_i,
	input  logic [decomp_pkg::DLEN_W-1:0]        dlen_i,
	input  logic [decomp_pkg::BEAT_BYTES*8-1:0]  data_i,
	input  logic                                 valid_i,
	input  logic                                 ready_i,
	output logic                                 almostfull_o,
	output logic [decomp_pkg::LINE_BYTES*8-1:0]  data_o,
	output logic [decomp_pkg::LINE_BYTES-1:0]    byte_en_o,
	output logic                                 valid_o,
	output logic                                 last_o,
	output logic                                 done_o
);

	logic [7:0]                       cbyte;
	logic                             cbyte_valid;
	logic                             cbyte_take;
	logic                             stream_end;
	logic [7:0]                       out_byte;
	logic                             out_byte_valid;
	logic [decomp_pkg::HIST_AW-1:0]   copy_offset;
	logic [7:0]                       hist_byte;
	logic                             packer_full;
	logic                             final_line;
	logic                             handshake;

	assign handshake = valid_o & ready_i;

	byte_unpacker u_byte_unpacker (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_i      (start_i),
		.clen_i       (clen_i),
		.data_i       (data_i),
		.valid_i      (valid_i),
		.take_i       (cbyte_take),
		.almostfull_o (almostfull_o),
		.byte_o       (cbyte),
		.byte_valid_o (cbyte_valid),
		.stream_end_o (stream_end)
	);

	token_fsm u_token_fsm (
		.clk              (clk),
		.rst_n            (rst_n),
		.start_i          (start_i),
		.byte_i           (cbyte),
		.byte_valid_i     (cbyte_valid),
		.stream_end_i     (stream_end),
		.stall_i          (packer_full),   // output line still waiting
		.hist_byte_i      (hist_byte),
		.take_o           (cbyte_take),
		.out_byte_o       (out_byte),
		.out_byte_valid_o (out_byte_valid),
		.copy_offset_o    (copy_offset)
	);

	// every produced byte goes to both history and packer on the same edge
	history_buffer u_history_buffer (
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (start_i),
		.wr_i      (out_byte_valid),
		.byte_i    (out_byte),
		.offset_i  (copy_offset),
		.rd_byte_o (hist_byte)
	);

	line_packer u_line_packer (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_i      (start_i),
		.dlen_i       (dlen_i),
		.byte_i       (out_byte),
		.byte_valid_i (out_byte_valid),
		.ready_i      (ready_i),
		.data_o       (data_o),
		.byte_en_o    (byte_en_o),
		.valid_o      (valid_o),
		.final_o      (final_line),
		.full_o       (packer_full)
	);

	burst_counter u_burst_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.start_i     (start_i),
		.handshake_i (handshake),
		.final_i     (final_line),
		.last_o      (last_o),
		.done_o      (done_o)
	);

endmodule

//--- src/token_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag parser, one byte in and one byte out per cycle
// literal lengths 1..64 and copy1 tokens only
// tag types 2 and 3 are skipped without output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module token_fsm
	import decomp_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start_i,
	input  logic [7:0]         byte_i,
	input  logic               byte_valid_i,
	input  logic               stream_end_i,
	input  logic               stall_i,
	input  logic [7:0]         hist_byte_i,
	output logic               take_o,
	output logic [7:0]         out_byte_o,
	output logic               out_byte_valid_o,
	output logic [HIST_AW-1:0] copy_offset_o
);

	fsm_state_e         state_q;
	tag_e               tag_type;
	logic [5:0]         len_q;        // bytes left minus one
	logic [HIST_AW-1:0] offset_q;

	assign tag_type      = tag_e'(byte_i[1:0]);
	assign copy_offset_o = offset_q;

	always_comb begin
		take_o           = 1'b0;
		out_byte_valid_o = 1'b0;
		out_byte_o       = byte_i;
		case (state_q)
			ST_TAG:
				take_o = byte_valid_i & ~stream_end_i;
			ST_LIT: begin
				take_o           = byte_valid_i & ~stall_i;
				out_byte_valid_o = byte_valid_i & ~stall_i;
			end
			ST_OFS:
				take_o = byte_valid_i;
			ST_COPY: begin
				out_byte_valid_o = ~stall_i;
				out_byte_o       = hist_byte_i;   // history read is combinational
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			len_q   <= '0;
		end else if (start_i) begin
			state_q <= ST_TAG;
			len_q   <= '0;
		end else begin
			case (state_q)
				ST_TAG: begin
					if (stream_end_i) begin
						state_q <= ST_IDLE;
					end else if (take_o) begin
						case (tag_type)
							TAG_LITERAL: begin
								len_q   <= byte_i[7:2];
								state_q <= ST_LIT;
							end
							TAG_COPY1: begin
								len_q   <= {3'b000, byte_i[4:2]} + 6'd3;   // length 4..11
								state_q <= ST_OFS;
							end
							default: ;   // copy2/copy4 not handled
						endcase
					end
				end
				ST_OFS:
					if (take_o)
						state_q <= ST_COPY;
				ST_LIT, ST_COPY: begin
					if (out_byte_valid_o) begin
						if (len_q == '0)
							state_q <= ST_TAG;
						else
							len_q <= len_q - 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	// offset high bits from the tag, low bits from the following byte
	always_ff @(posedge clk) begin
		if (state_q == ST_TAG && take_o)
			offset_q[HIST_AW-1:8] <= byte_i[7:5];
		if (state_q == ST_OFS && take_o)
			offset_q[7:0] <= byte_i;
	end

endmodule

//--- tests/tb_stream.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random token streams and their expected expansion
// literals of 1..60 bytes and copy1 tokens only
// the stream is padded with junk to whole 64-byte beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_STREAM_SVH
`define TB_STREAM_SVH

logic [31:0] lfsr_q;          // shared random state
logic [7:0]  cstream[$];      // compressed bytes, padded
logic [7:0]  expect_q[$];     // expected decompressed bytes

// one step of a 32-bit galois lfsr
function automatic logic [31:0] lfsr_next(input logic [31:0] st);
	logic [31:0] nx;
	nx = st >> 1;
	if (st[0])
		nx = nx ^ 32'h8020_0003;
	return nx;
endfunction

// n random bits, one lfsr step per bit
function automatic int unsigned rand_bits(input int n);
	int unsigned r;
	int          k;
	r = 0;
	for (k = 0; k < n; k++) begin
		r      = (r << 1) | {31'd0, lfsr_q[0]};
		lfsr_q = lfsr_next(lfsr_q);
	end
	return r;
endfunction

// builds a stream that expands to exactly target bytes
task automatic build_job(input int target, input bit lit_only, output int clen);
	int         produced;
	int         len;
	int         ofs;
	int         span;
	int         i;
	logic [7:0] b;
	cstream.delete();
	expect_q.delete();
	produced = 0;
	while (produced < target) begin
		if (produced == 0 || lit_only || target - produced < 4 || rand_bits(1) == 0) begin
			len = 1 + int'(rand_bits(6) % 60);
			if (len > target - produced)
				len = target - produced;
			cstream.push_back({6'(len - 1), 2'b00});   // literal tag
			for (i = 0; i < len; i++) begin
				b = 8'(rand_bits(8));
				cstream.push_back(b);
				expect_q.push_back(b);
			end
		end else begin
			len = 4 + int'(rand_bits(3));
			if (len > target - produced)
				len = target - produced;
			span = (produced < 2047) ? produced : 2047;
			if (rand_bits(2) == 0 && span > 4)
				span = 4;   // short distance, copy overlaps itself
			ofs = 1 + int'(rand_bits(12) % span);
			cstream.push_back({ofs[10:8], 3'(len - 4), 2'b01});
			cstream.push_back(ofs[7:0]);
			for (i = 0; i < len; i++)
				expect_q.push_back(expect_q[expect_q.size() - ofs]);
		end
		produced += len;
	end
	clen = cstream.size();
	while (cstream.size() % 64 != 0)
		cstream.push_back(8'(rand_bits(8)));   // junk past the end
endtask

`endif

//--- tests/tb_snappy_decomp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the snappy-style decompressor
// random jobs with random ready_i, compared with a model
// stops at the first mismatch or timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_snappy_decomp;

	localparam int LINE_LEN        = 64;
	localparam int LINES_PER_BURST = 16;
	localparam int BEAT_TIMEOUT    = 5000;   // cycles
	localparam int LINE_TIMEOUT    = 2000;

	logic         clk;
	logic         rst_n;
	logic         start_i;
	logic [34:0]  clen_i;
	logic [31:0]  dlen_i;
	logic [511:0] data_i;
	logic         valid_i;
	logic         ready_i;
	logic         almostfull_o;
	logic [511:0] data_o;
	logic [63:0]  byte_en_o;
	logic         valid_o;
	logic         last_o;
	logic         done_o;

	`include "tb_stream.svh"

	snappy_decomp_top u_snappy_decomp_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_i      (start_i),
		.clen_i       (clen_i),
		.dlen_i       (dlen_i),
		.data_i       (data_i),
		.valid_i      (valid_i),
		.ready_i      (ready_i),
		.almostfull_o (almostfull_o),
		.data_o       (data_o),
		.byte_en_o    (byte_en_o),
		.valid_o      (valid_o),
		.last_o       (last_o),
		.done_o       (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout while waiting for %s at %0t ns", what, $time);
		$display("Test failed");
		$fatal(1, "stopping after timeout");
	endtask

	// holds each beat until almostfull_o was low at the edge
	task automatic drive_beats();
		logic [511:0] beat;
		int           b;
		int           i;
		int           waited;
		bit           taken;
		for (b = 0; b < cstream.size() / 64; b++) begin
			for (i = 0; i < 64; i++)
				beat[i*8 +: 8] = cstream[b*64 + i];
			data_i  = beat;
			valid_i = 1'b1;
			waited  = 0;
			taken   = 1'b0;
			while (!taken) begin
				taken = !almostfull_o;   // registered, stable until the edge
				@(posedge clk);
				#1;
				waited++;
				if (!taken && waited > BEAT_TIMEOUT)
					fail_timeout("a beat to be accepted");
			end
		end
		valid_i = 1'b0;
	endtask

	task automatic check_line(input int dlen, inout int line_no, inout int pos,
			output bit is_final);
		int          n;
		int          i;
		logic [63:0] mask;
		n = dlen - pos;
		if (n > LINE_LEN)
			n = LINE_LEN;
		mask = (n == LINE_LEN) ? '1 : ((64'd1 << n) - 64'd1);
		line_no++;
		is_final = (pos + n == dlen);
		check_value($sformatf("byte_en_o of line %0d", line_no), byte_en_o, mask);
		for (i = 0; i < n; i++)
			check_value($sformatf("line %0d byte %0d", line_no, i),
				64'(data_o[i*8 +: 8]), 64'(expect_q[pos + i]));
		check_value($sformatf("last_o of line %0d", line_no), 64'(last_o),
			64'(is_final || (line_no % LINES_PER_BURST == 0)));
		pos += n;
	endtask

	// random ready_i, line checks and the done pulse
	task automatic watch_lines(input int dlen);
		int line_no;
		int pos;
		int idle;
		bit done_due;
		bit finished;
		line_no  = 0;
		pos      = 0;
		idle     = 0;
		done_due = 1'b0;
		finished = 1'b0;
		while (!finished) begin
			check_value("done_o", 64'(done_o), 64'(done_due));
			if (done_due) begin
				finished = 1'b1;
			end else begin
				ready_i = (rand_bits(2) != 0);   // high about 3 cycles in 4
				if (valid_o && ready_i) begin
					check_line(dlen, line_no, pos, done_due);
					idle = 0;
				end else begin
					idle++;
					if (idle > LINE_TIMEOUT)
						fail_timeout("an output line");
				end
				@(posedge clk);
				#1;
			end
		end
		ready_i = 1'b0;
		@(posedge clk);
		#1;
		check_value("done_o one cycle after its pulse", 64'(done_o), 64'd0);
	endtask

	task automatic run_job(input int target, input bit lit_only);
		int clen;
		build_job(target, lit_only, clen);
		clen_i  = 35'(clen);
		dlen_i  = 32'(expect_q.size());
		start_i = 1'b1;
		@(posedge clk);
		#1;
		start_i = 1'b0;
		fork
			drive_beats();
			watch_lines(expect_q.size());
		join
	endtask

	initial begin
		int j;
		rst_n   = 1'b0;
		start_i = 1'b0;
		clen_i  = '0;
		dlen_i  = '0;
		data_i  = '0;
		valid_i = 1'b0;
		ready_i = 1'b0;
		lfsr_q  = 32'hbef0_11ce;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("valid_o after reset", 64'(valid_o), 64'd0);
		check_value("last_o after reset", 64'(last_o), 64'd0);
		check_value("done_o after reset", 64'(done_o), 64'd0);
		check_value("almostfull_o after reset", 64'(almostfull_o), 64'd0);

		run_job(700, 1'b1);    // literals only
		run_job(1024, 1'b0);   // whole lines, final one full
		run_job(3000, 1'b0);
		run_job(65, 1'b0);
		for (j = 0; j < 4; j++)
			run_job(1 + int'(rand_bits(11)), 1'b0);

		$display("Test completed successfully");
		$finish;
	end

endmodule
